/* rtl/boot_ram_pkg.sv */
// Widths and request structs shared by the boot RAM blocks and compiled ahead of them
package boot_ram_pkg;

   //////////////////////////////
   // Port and line geometry
   //////////////////////////////

   localparam int WORD_BITS = 64;    // Access port
   localparam int LINE_BITS = 128;   // Storage line

   localparam int WORD_BYTES = WORD_BITS / 8;
   localparam int LINE_BYTES = LINE_BITS / 8;

   // Word lanes per line
   localparam int WORD_LANES = LINE_BITS / WORD_BITS;

   localparam int OFFSET_BITS = $clog2(WORD_BYTES);   // Byte inside a word
   localparam int LANE_BITS   = $clog2(WORD_LANES);   // Word inside a line

   // Byte address field, 64 KB ceiling
   localparam int MAX_ADDR_BITS = 16;

   //////////////////////////////
   // Request structs
   //////////////////////////////

   // One access on the 64-bit word port
   typedef struct packed {
      logic                     en;      // Access strobe
      logic [WORD_BYTES-1:0]    we;      // Byte write enables
      logic [MAX_ADDR_BITS-1:0] addr;    // Byte address
      logic [WORD_BITS-1:0]     wdata;
   } word_req_t;

   // Same access seen from the 128-bit line array
   typedef struct packed {
      logic                     en;
      logic [MAX_ADDR_BITS-1:0] block;        // Line index
      logic [LANE_BITS-1:0]     lane;         // Word lane in the line
      logic [LINE_BYTES-1:0]    we_line;      // Mask already in lane position
      logic [LINE_BITS-1:0]     wdata_line;   // Write word in every lane
   } line_req_t;

endpackage

/* rtl/bram_req_decode.sv */
// Input side of the boot RAM that maps a 64-bit word access onto a 128-bit line request
`timescale 1ns/1ps

module bram_req_decode
#(
   parameter int ADDR_BITS = 12
)
(
   input  logic                    i_etx_clk,
   input  logic                    i_rst,
   input  boot_ram_pkg::word_req_t i_req,
   output boot_ram_pkg::line_req_t o_line_req
);

   // Address bits that land inside the memory
   localparam logic [boot_ram_pkg::MAX_ADDR_BITS-1:0] ADDR_MASK =
      ~({boot_ram_pkg::MAX_ADDR_BITS{1'b1}} << ADDR_BITS);

   // Line index starts above lane and byte offset
   localparam int BLOCK_SHIFT = boot_ram_pkg::LANE_BITS + boot_ram_pkg::OFFSET_BITS;

   logic [boot_ram_pkg::MAX_ADDR_BITS-1:0] addr_in;   // Wrapped byte address
   logic [boot_ram_pkg::LANE_BITS-1:0]     lane;
   logic [boot_ram_pkg::LINE_BYTES-1:0]    we_line;

   //////////////////////////////
   // Address split
   //////////////////////////////

   assign addr_in = i_req.addr & ADDR_MASK;
   assign lane    = addr_in[boot_ram_pkg::OFFSET_BITS +: boot_ram_pkg::LANE_BITS];

   //////////////////////////////
   // Byte mask and data steering
   //////////////////////////////

   // Word mask goes to the addressed lane only
   always_comb
   begin
      we_line = '0;
      for (int l = 0; l < boot_ram_pkg::WORD_LANES; l++)
      begin
         if (int'(lane) == l)
         begin
            we_line[l*boot_ram_pkg::WORD_BYTES +: boot_ram_pkg::WORD_BYTES] = i_req.we;
         end
      end
   end

   always_comb
   begin
      o_line_req.en         = i_req.en;
      o_line_req.block      = addr_in >> BLOCK_SHIFT;
      o_line_req.lane       = lane;
      o_line_req.we_line    = we_line;
      // Same word in every lane, the mask picks the one written
      o_line_req.wdata_line = {boot_ram_pkg::WORD_LANES{i_req.wdata}};
   end

   //////////////////////////////
   // Range guard
   //////////////////////////////

   // Bits above the memory size are dropped and the access wraps
   a_addr_range: assert property (
      @(posedge i_etx_clk) disable iff (i_rst)
      i_req.en |-> ((i_req.addr & ~ADDR_MASK) == '0)
   )
   else
   begin
      $warning("Access at %h wraps beyond %0d address bits",
               $sampled(i_req.addr), ADDR_BITS);
   end

endmodule

/* rtl/bram_line_store.sv */
// Line array of the boot RAM with byte writes and a registered index that drives the read lane mux
`timescale 1ns/1ps

module bram_line_store
#(
   parameter int ADDR_BITS = 12
)
(
   input  logic                               i_etx_clk,
   input  logic                               i_rst,
   input  boot_ram_pkg::line_req_t            i_line_req,
   output logic [boot_ram_pkg::WORD_BITS-1:0] o_rdata
);

   localparam int LINES    = (2 ** ADDR_BITS) / boot_ram_pkg::LINE_BYTES;
   localparam int BLK_BITS = ADDR_BITS - boot_ram_pkg::LANE_BITS - boot_ram_pkg::OFFSET_BITS;

   logic [boot_ram_pkg::LINE_BITS-1:0]  ram [LINES];
   logic [BLK_BITS-1:0]                 blk;        // Index of this access
   logic [BLK_BITS-1:0]                 blk_q;      // Index of last access
   logic [boot_ram_pkg::LANE_BITS-1:0]  lane_q;
   logic [boot_ram_pkg::LINE_BITS-1:0]  line_rd;
   logic [boot_ram_pkg::WORD_LANES-1:0] lane_hit;   // Lanes with any byte enabled

   assign blk = i_line_req.block[BLK_BITS-1:0];

   //////////////////////////////
   // Byte writes
   //////////////////////////////

   always_ff @(posedge i_etx_clk)
   begin
      if (i_line_req.en)
      begin
         for (int b = 0; b < boot_ram_pkg::LINE_BYTES; b++)
         begin
            if (i_line_req.we_line[b])
               ram[blk][b*8 +: 8] <= i_line_req.wdata_line[b*8 +: 8];
         end
      end
   end

   //////////////////////////////
   // Read index and lane select
   //////////////////////////////

   // Held while idle so the output keeps the last word
   always_ff @(posedge i_etx_clk)
   begin
      if (i_rst)
      begin
         blk_q  <= '0;
         lane_q <= '0;
      end
      else if (i_line_req.en)
      begin
         blk_q  <= blk;
         lane_q <= i_line_req.lane;
      end
   end

   // Array read after the write edge so a write shows up here
   assign line_rd = ram[blk_q];
   assign o_rdata = line_rd[lane_q * boot_ram_pkg::WORD_BITS +: boot_ram_pkg::WORD_BITS];

   //////////////////////////////
   // Lane mask check
   //////////////////////////////

   for (genvar l = 0; l < boot_ram_pkg::WORD_LANES; l++)
   begin : g_lane_hit
      assign lane_hit[l] =
         |i_line_req.we_line[l*boot_ram_pkg::WORD_BYTES +: boot_ram_pkg::WORD_BYTES];
   end

   // Enabled bytes sit in one lane and that lane is the one addressed
   a_one_lane: assert property (
      @(posedge i_etx_clk) disable iff (i_rst)
      i_line_req.en |->
         ($onehot0(lane_hit) && ((lane_hit == '0) || lane_hit[i_line_req.lane]))
   );

endmodule

/* rtl/boot_ram_top.sv */
// Top level of the boot RAM with one 64-bit word port on the Ethernet TX clock
`timescale 1ns/1ps

module boot_ram_top
#(
   parameter int ADDR_BITS = 12   // 4 KB
)
(
   input  logic                               i_etx_clk,
   input  logic                               i_rst,
   input  boot_ram_pkg::word_req_t            i_req,
   output logic [boot_ram_pkg::WORD_BITS-1:0] o_rdata
);

   // Decoded request into the array
   boot_ram_pkg::line_req_t line_req;

   // At least two lines and no more than the address field holds
   initial
   begin
      assert ((ADDR_BITS >= 5) && (ADDR_BITS <= boot_ram_pkg::MAX_ADDR_BITS))
      else
         $fatal(1, "ADDR_BITS %0d outside 5..%0d", ADDR_BITS,
                boot_ram_pkg::MAX_ADDR_BITS);
   end

   //////////////////////////////
   // Request decode
   //////////////////////////////

   bram_req_decode
   #(
      .ADDR_BITS  ( ADDR_BITS )
   )
   decode_i
   (
      .i_etx_clk  ( i_etx_clk ),
      .i_rst      ( i_rst     ),
      .i_req      ( i_req     ),
      .o_line_req ( line_req  )
   );

   //////////////////////////////
   // Line store
   //////////////////////////////

   // One cycle read latency from any enabled access
   bram_line_store
   #(
      .ADDR_BITS  ( ADDR_BITS )
   )
   store_i
   (
      .i_etx_clk  ( i_etx_clk ),
      .i_rst      ( i_rst     ),
      .i_line_req ( line_req  ),
      .o_rdata    ( o_rdata   )
   );

endmodule

/* sim/boot_ram_tb.sv */
// Boot RAM testbench that replays the pattern file and random accesses against a byte model
`timescale 1ns/1ps

module boot_ram_tb;

   localparam int          ADDR_BITS  = 12;
   localparam int          MEM_BYTES  = 2 ** ADDR_BITS;
   localparam int          MAX_ROWS   = 64;
   localparam int          ROW_WORDS  = 5;     // Op, address, mask, data, expected
   localparam int          N_RAND     = 400;
   localparam int          RST_CYCLES = 16;
   localparam logic [31:0] RAND_SEED  = 32'haacd_bb75;

   localparam logic [1:0] OP_IDLE  = 2'd0;
   localparam logic [1:0] OP_WRITE = 2'd1;
   localparam logic [1:0] OP_READ  = 2'd2;

   logic                               i_etx_clk;
   logic                               i_rst;
   boot_ram_pkg::word_req_t            i_req;
   logic [boot_ram_pkg::WORD_BITS-1:0] o_rdata;

   logic [63:0] pat_mem [MAX_ROWS*ROW_WORDS];
   int          n_pat;
   logic        pat_loaded;

   // Byte model of the whole memory
   logic [7:0]  mem_model [MEM_BYTES];
   logic        mem_known [MEM_BYTES];   // Byte written at least once
   logic [15:0] last_addr;
   logic        any_access;

   logic        pend_valid;   // Access in flight, checked next cycle
   logic [63:0] pend_exp;
   logic [63:0] pend_known;

   int checks;
   int errors;

   boot_ram_top
   #(
      .ADDR_BITS ( ADDR_BITS )
   )
   boot_ram_top_i
   (
      .i_etx_clk ( i_etx_clk ),
      .i_rst     ( i_rst     ),
      .i_req     ( i_req     ),
      .o_rdata   ( o_rdata   )
   );

   initial
   begin
      i_etx_clk = 1'b0;
      forever #10 i_etx_clk = ~i_etx_clk;
   end

   //////////////////////////////
   // Model and checks
   //////////////////////////////

   task automatic update_model(input logic [1:0] op, input logic [15:0] addr,
                               input logic [7:0] mask, input logic [63:0] data,
                               output logic [63:0] exp, output logic [63:0] known);
      int base;
      if (op != OP_IDLE)
      begin
         last_addr  = addr;
         any_access = 1'b1;
      end
      base = int'(last_addr) % MEM_BYTES;
      base = base - (base % 8);   // Word aligned
      for (int b = 0; b < 8; b++)
      begin
         if ((op == OP_WRITE) && mask[b])
         begin
            mem_model[base+b] = data[b*8 +: 8];
            mem_known[base+b] = 1'b1;
         end
         exp[b*8 +: 8]   = mem_model[base+b];
         known[b*8 +: 8] = {8{mem_known[base+b]}};
      end
   endtask

   task automatic check_rdata(input logic [63:0] exp, input logic [63:0] known);
      checks++;
      assert (((o_rdata ^ exp) & known) == 64'd0)
      else
      begin
         errors++;
         $display("MISMATCH at %0t: o_rdata %h, model expects %h (known bytes %h)",
                  $time, o_rdata, exp, known);
      end
   endtask

   // Drives one access, then checks the one sampled at this edge
   task automatic apply_access(input logic [1:0] op, input logic [15:0] addr,
                               input logic [7:0] mask, input logic [63:0] data,
                               output logic [63:0] exp, output logic [63:0] known);
      boot_ram_pkg::word_req_t req;
      req.en    = (op != OP_IDLE);
      req.we    = (op == OP_WRITE) ? mask : 8'h00;
      req.addr  = addr;
      req.wdata = data;
      @(posedge i_etx_clk);
      i_req <= req;
      @(negedge i_etx_clk);
      if (pend_valid)
         check_rdata(pend_exp, pend_known);
      update_model(op, addr, mask, data, exp, known);
      pend_valid = any_access;
      pend_exp   = exp;
      pend_known = known;
   endtask

   //////////////////////////////
   // Test phases
   //////////////////////////////

   task automatic run_patterns();
      logic [1:0]  op;
      logic [63:0] exp;
      logic [63:0] known;
      logic [63:0] file_exp;
      int          err0;
      err0 = errors;
      for (int i = 0; i < n_pat; i++)
      begin
         op       = pat_mem[i*ROW_WORDS][1:0];
         file_exp = pat_mem[i*ROW_WORDS+4];
         if (pat_mem[i*ROW_WORDS] > 64'd2)
         begin
            errors++;
            $display("Pattern row %0d has an unknown operation code, run as idle", i);
            op = OP_IDLE;
         end
         apply_access(op, pat_mem[i*ROW_WORDS+1][15:0], pat_mem[i*ROW_WORDS+2][7:0],
                      pat_mem[i*ROW_WORDS+3], exp, known);
         if (any_access)
         begin
            checks++;
            assert (((file_exp ^ exp) & known) == 64'd0)
            else
            begin
               errors++;
               $display("Pattern row %0d: file value %h disagrees with the model value %h",
                        i, file_exp, exp);
            end
         end
      end
      apply_access(OP_IDLE, 16'h0000, 8'h00, 64'd0, exp, known);   // Flush last check
      $display("Pattern test: %0d accesses, %0d errors", n_pat, errors - err0);
   endtask

   task automatic run_random();
      logic [1:0]  op;
      logic [15:0] addr;
      logic [7:0]  mask;
      logic [63:0] data;
      logic [63:0] exp;
      logic [63:0] known;
      int          err0;
      err0 = errors;
      for (int i = 0; i < N_RAND; i++)
      begin
         op   = 2'($urandom % 3);
         addr = 16'($urandom & 32'h0000_00ff);   // Small window so reads hit written words
         mask = 8'($urandom);
         data = {$urandom, $urandom};
         apply_access(op, addr, mask, data, exp, known);
      end
      apply_access(OP_IDLE, 16'h0000, 8'h00, 64'd0, exp, known);
      $display("Random test: %0d accesses, %0d errors", N_RAND, errors - err0);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial
   begin
      void'($urandom(RAND_SEED));
      i_rst      = 1'b1;
      i_req      = '0;
      pend_valid = 1'b0;
      any_access = 1'b0;
      last_addr  = 16'h0000;
      checks     = 0;
      errors     = 0;
      n_pat      = 0;
      pat_loaded = 1'b0;
      for (int a = 0; a < MEM_BYTES; a++)
      begin
         mem_model[a] = 8'h00;
         mem_known[a] = 1'b0;
      end
      for (int w = 0; w < MAX_ROWS*ROW_WORDS; w++)
         pat_mem[w] = '1;   // All ones marks the end of the rows
      $readmemh("sim/boot_ram_patterns.txt", pat_mem);
      while ((n_pat < MAX_ROWS) && (pat_mem[n_pat*ROW_WORDS] != '1))
         n_pat++;
      if (n_pat == 0)
      begin
         errors++;
         $display("Pattern file holds no access rows");
      end
      pat_loaded = 1'b1;

      repeat (RST_CYCLES) @(posedge i_etx_clk);
      i_rst <= 1'b0;

      run_patterns();
      run_random();

      $display("Checks: %0d run, %0d failed", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // Two cycles per access plus margin
   initial
   begin
      wait (pat_loaded);
      #((n_pat + N_RAND + RST_CYCLES) * 40 + 2000);
      $display("Watchdog timeout, the run did not finish in time");
      $display("Test failed");
      $finish;
   end

endmodule

/* sim/boot_ram_patterns.txt */
// Boot RAM accesses, one per line, all fields hex
// op (0 idle, 1 write, 2 read), byte address, byte mask, write data, expected o_rdata
// Full-mask write and read back
1 0010 ff 1122334455667788 1122334455667788
2 0010 00 0000000000000000 1122334455667788
// Partial byte masks
1 0010 0f aaaaaaaaaaaaaaaa 11223344aaaaaaaa
2 0010 00 0000000000000000 11223344aaaaaaaa
1 0010 81 deadbeefcafef00d de223344aaaaaa0d
2 0010 00 0000000000000000 de223344aaaaaa0d
// Both lanes of line 2
1 0020 ff 0123456789abcdef 0123456789abcdef
1 0028 ff fedcba9876543210 fedcba9876543210
2 0020 00 0000000000000000 0123456789abcdef
2 0028 00 0000000000000000 fedcba9876543210
1 0028 3c 0000ffffffff0000 fedcffffffff3210
2 0020 00 0000000000000000 0123456789abcdef
// Idle hold and a write seen one cycle later
0 0000 00 0000000000000000 0123456789abcdef
0 0000 00 0000000000000000 0123456789abcdef
1 0020 ff 0f0f0f0f0f0f0f0f 0f0f0f0f0f0f0f0f
0 0000 00 0000000000000000 0f0f0f0f0f0f0f0f
1 0028 00 ffffffffffffffff fedcffffffff3210
2 0015 00 0000000000000000 de223344aaaaaa0d
// Upper address bits wrap
2 1010 00 0000000000000000 de223344aaaaaa0d
1 f038 ff 8899aabbccddeeff 8899aabbccddeeff
2 0038 00 0000000000000000 8899aabbccddeeff
// Top line of the memory
1 0ff8 ff 0badc0de12345678 0badc0de12345678
1 0ff0 ff 7766554433221100 7766554433221100
2 0ff8 00 0000000000000000 0badc0de12345678
2 0ff0 00 0000000000000000 7766554433221100
0 0000 00 0000000000000000 7766554433221100

/* boot_ram.f */
rtl/boot_ram_pkg.sv
rtl/bram_req_decode.sv
rtl/bram_line_store.sv
rtl/boot_ram_top.sv
sim/boot_ram_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the boot RAM testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module boot_ram_tb \
   -f boot_ram.f -o boot_ram_sim || exit 1

out=$(./obj_dir/boot_ram_sim)
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && echo "Simulation passed" \
   || { echo "Simulation did not pass"; exit 1; }
